//--- Bender.yml
package:
  name: c2h_stream_gen

sources:
  - src/c2h_gen_pkg.sv
  - src/c2h_req_stage.sv
  - src/c2h_beat_sequencer.sv
  - src/c2h_meta_gen.sv
  - src/c2h_done_queue.sv
  - src/c2h_burst_fifo.sv
  - src/c2h_drain_ctrl.sv
  - src/c2h_stream_gen.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_c2h_stream_gen.sv

//--- files.f
+incdir+tb
src/c2h_gen_pkg.sv
src/c2h_req_stage.sv
src/c2h_beat_sequencer.sv
src/c2h_meta_gen.sv
src/c2h_done_queue.sv
src/c2h_burst_fifo.sv
src/c2h_drain_ctrl.sv
src/c2h_stream_gen.sv
tb/tb_c2h_stream_gen.sv

//--- src/c2h_beat_sequencer.sv
/* Beats are contiguous within a packet and a new packet may start as the last beat goes.
   room_i must already account for a push in the current cycle */
module c2h_beat_sequencer #(
  parameter int DATA_WIDTH  = 64,
  parameter int BYTE_CREDIT = 4096
) (
  input  logic                              user_clk,
  input  logic                              user_reset_n,
  input  logic                              req_vld_i,
  input  c2h_gen_pkg::c2h_cmd_t             req_cmd_i,
  input  logic                              room_i,       // Both done queues can take one
  input  logic                              beat_rdy_i,   // FIFO has space
  output logic                              take_o,       // Pending request consumed
  output logic                              beat_vld_o,
  output logic                              beat_last_o,
  output c2h_gen_pkg::c2h_cmd_t             cur_cmd_o,    // Active packet
  output logic [c2h_gen_pkg::LEN_WIDTH-1:0] byte_idx_o,   // Offset of current beat
  output logic                              done_o,       // Last beat accepted
  output logic                              dec_credit_o
);
  import c2h_gen_pkg::*;

  localparam int BUS_BYTES = DATA_WIDTH / 8;

  logic [LEN_WIDTH:0] byte_cnt_q;    // Bytes up to and including the current beat
  logic [LEN_WIDTH:0] byte_cnt_nxt;
  logic               beat_fire;

  assign beat_fire    = beat_vld_o & beat_rdy_i;
  assign done_o       = beat_fire & beat_last_o;
  // Start when idle or when the active packet ends this cycle
  assign take_o       = req_vld_i & room_i & (~beat_vld_o | done_o);
  assign byte_cnt_nxt = byte_cnt_q + (LEN_WIDTH+1)'(BUS_BYTES);
  assign byte_idx_o   = LEN_WIDTH'(byte_cnt_q - BUS_BYTES);

  // One decrement per credit boundary, plus the partial tail
  assign dec_credit_o = beat_fire & (((byte_cnt_q % BYTE_CREDIT) == 0) | beat_last_o);

  ////////////////////
  // Beat walk
  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      beat_vld_o <= 1'b0;
    end else if (take_o) begin
      beat_vld_o <= 1'b1;
    end else if (done_o) begin
      beat_vld_o <= 1'b0;
    end
  end

  always_ff @(posedge user_clk) begin
    if (take_o) begin
      cur_cmd_o   <= req_cmd_i;
      byte_cnt_q  <= (LEN_WIDTH+1)'(BUS_BYTES);
      beat_last_o <= (req_cmd_i.len <= LEN_WIDTH'(BUS_BYTES));  // Fits one beat
    end else if (beat_fire) begin
      byte_cnt_q  <= byte_cnt_nxt;
      beat_last_o <= (byte_cnt_nxt >= (LEN_WIDTH+1)'(cur_cmd_o.len));
    end
  end

  // FIFO back-pressure must not disturb the offered beat
  a_beat_hold: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    beat_vld_o && !beat_rdy_i |=> beat_vld_o && $stable(cur_cmd_o) && $stable(byte_idx_o));

endmodule

//--- src/c2h_burst_fifo.sv
/* FWFT FIFO, FIFO_DEPTH a power of two and larger than one credit of beats.
   Read data is combinational from the array */
module c2h_burst_fifo #(
  parameter int DATA_WIDTH  = 64,
  parameter int FIFO_DEPTH  = 32,
  parameter int BYTE_CREDIT = 4096
) (
  input  logic                              user_clk,
  input  logic                              user_reset_n,
  input  logic                              wr_vld_i,
  input  logic [DATA_WIDTH-1:0]             wr_data_i,
  input  logic                              wr_last_i,
  input  logic [c2h_gen_pkg::QID_WIDTH-1:0] wr_qid_i,
  input  logic [c2h_gen_pkg::LEN_WIDTH-1:0] wr_len_i,
  output logic                              wr_rdy_o,
  output logic                              rd_vld_o,
  output logic [DATA_WIDTH-1:0]             rd_data_o,
  output logic                              rd_last_o,
  output logic [c2h_gen_pkg::QID_WIDTH-1:0] rd_qid_o,
  output logic [c2h_gen_pkg::LEN_WIDTH-1:0] rd_len_o,
  input  logic                              rd_en_i,
  output logic                              almost_empty_o,  // One entry or none
  output logic                              nearly_full_o    // Under a credit of room
);
  import c2h_gen_pkg::*;

  localparam int AW           = $clog2(FIFO_DEPTH);
  localparam int CREDIT_BEATS = BYTE_CREDIT / (DATA_WIDTH / 8);

  typedef struct packed {
    logic                  last;
    c2h_cmd_t              cmd;
    logic [DATA_WIDTH-1:0] data;
  } fifo_ent_t;

  fifo_ent_t     mem_q [FIFO_DEPTH];
  fifo_ent_t     rd_ent;
  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW:0]   cnt_q;
  logic          wr_fire, rd_fire;

  assign wr_rdy_o       = (cnt_q != (AW+1)'(FIFO_DEPTH));
  assign rd_vld_o       = (cnt_q != '0);
  assign wr_fire        = wr_vld_i & wr_rdy_o;
  assign rd_fire        = rd_en_i & rd_vld_o;
  assign almost_empty_o = (cnt_q <= (AW+1)'(1));
  assign nearly_full_o  = ((FIFO_DEPTH - cnt_q) < CREDIT_BEATS);

  assign rd_ent    = mem_q[rd_ptr_q];  // Head shows without a read
  assign rd_data_o = rd_ent.data;
  assign rd_last_o = rd_ent.last;
  assign rd_qid_o  = rd_ent.cmd.qid;
  assign rd_len_o  = rd_ent.cmd.len;

  always_ff @(posedge user_clk) begin
    if (wr_fire) begin
      mem_q[wr_ptr_q] <= {wr_last_i, wr_qid_i, wr_len_i, wr_data_i};
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + AW'(wr_fire);  // Pointers wrap at the power of two
      rd_ptr_q <= rd_ptr_q + AW'(rd_fire);
      cnt_q    <= cnt_q + (AW+1)'(wr_fire) - (AW+1)'(rd_fire);
    end
  end

endmodule

//--- src/c2h_done_queue.sv
/* Two-entry ordered queue. A pop while empty is ignored */
module c2h_done_queue (
  input  logic                  user_clk,
  input  logic                  user_reset_n,
  input  logic                  push_i,
  input  c2h_gen_pkg::c2h_cmd_t push_cmd_i,
  input  logic                  pop_i,       // Consumer acknowledge
  output logic                  full_o,
  output logic                  vld_o,       // Head entry present
  output c2h_gen_pkg::c2h_cmd_t cmd_o
);
  import c2h_gen_pkg::*;

  c2h_cmd_t   ent_q [2];  // Entry 0 is the head
  logic [1:0] cnt_q;
  logic       wr_idx;     // Tail slot after any shift
  logic       pop_en;

  assign full_o = (cnt_q == 2'd2);
  assign vld_o  = (cnt_q != 2'd0);
  assign cmd_o  = ent_q[0];
  assign pop_en = pop_i & vld_o;
  assign wr_idx = (cnt_q == 2'd1) ^ pop_en;

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_q + {1'b0, push_i} - {1'b0, pop_en};
    end
  end

  ////////////////////
  // Shift on pop, then write the tail
  always_ff @(posedge user_clk) begin
    if (pop_en) begin
      ent_q[0] <= ent_q[1];
    end
    if (push_i) begin
      ent_q[wr_idx] <= push_cmd_i;  // Overrides the shift into slot 0
    end
  end

  // Sequencer start check has to keep this from overflowing
  a_no_push_full: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    push_i |-> !full_o);

endmodule

//--- src/c2h_drain_ctrl.sv
/* Idle timeout and start_now also flush a last lone beat. Gate opens one cycle after
   a start condition; stop_now shuts it at once */
module c2h_drain_ctrl #(
  parameter int IDLE_LIMIT = 4095
) (
  input  logic                     user_clk,
  input  logic                     user_reset_n,
  input  c2h_gen_pkg::drain_ctrl_t ctrl_i,
  input  logic                     wb_is_full_i,    // Completion side backed up
  input  logic                     wr_fire_i,       // Beat entered the FIFO
  input  logic                     almost_empty_i,
  input  logic                     nearly_full_i,
  output logic                     gate_o           // FIFO output enable
);
  import c2h_gen_pkg::*;

  localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);

  logic [IDLE_W-1:0] idle_cnt_q;  // Cycles since last write, saturating
  logic              idle_done;
  logic              start;
  drain_state_e      state_q;

  assign idle_done = (idle_cnt_q == IDLE_W'(IDLE_LIMIT));
  // A new write restarts the idle wait
  assign start = ctrl_i.start_now | (idle_done & ~wr_fire_i) |
                 (~almost_empty_i & (nearly_full_i | wb_is_full_i));
  assign gate_o = (state_q == DRAIN_BURST) & ~ctrl_i.stop_now;

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      idle_cnt_q <= '0;
    end else if (wr_fire_i) begin
      idle_cnt_q <= '0;
    end else if (!idle_done) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  ////////////////////
  // Hold/burst FSM
  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      state_q <= DRAIN_HOLD;
    end else begin
      case (state_q)
        DRAIN_HOLD:  if (start) state_q <= DRAIN_BURST;
        DRAIN_BURST: if (almost_empty_i && !start) state_q <= DRAIN_HOLD;  // Burst done
        default:     state_q <= DRAIN_HOLD;
      endcase
    end
  end

endmodule

//--- src/c2h_gen_pkg.sv
/* Widths are fixed by the DMA interface. The metadata word is always 64 bits and the bus
   carries whole copies of it */
package c2h_gen_pkg;

  localparam int QID_WIDTH  = 11;  // Queue ID
  localparam int LEN_WIDTH  = 16;  // Length and byte index
  localparam int META_WIDTH = 64;
  localparam int CRC_WIDTH  = 8;
  // Upper dword minus check byte, queue ID and control
  localparam int STUB_WIDTH = 32 - CRC_WIDTH - QID_WIDTH - 2;

  // One transfer as it moves from request slot to done queues
  typedef struct packed {
    logic [QID_WIDTH-1:0] qid;
    logic [LEN_WIDTH-1:0] len;
  } c2h_cmd_t;

  // Only two legal codes, 01 and 10 are reserved
  typedef enum logic [1:0] {
    META_PLAIN    = 2'b00,
    META_INVERTED = 2'b11
  } meta_ctrl_e;

  ////////////////////
  // Metadata word, high to low
  typedef struct packed {
    logic [CRC_WIDTH-1:0]  crc;       // XOR of 7-bit groups
    logic [STUB_WIDTH-1:0] stub;      // Random filler
    logic [QID_WIDTH-1:0]  qid;
    meta_ctrl_e            ctrl;      // Never inverted
    logic [LEN_WIDTH-1:0]  byte_idx;  // Offset of this beat
    logic [LEN_WIDTH-1:0]  len;       // Bytes in the transfer
  } meta_hdr_t;

  typedef enum logic {
    DRAIN_HOLD,   // Collect beats
    DRAIN_BURST   // Empty the FIFO
  } drain_state_e;

  typedef struct packed {
    logic start_now;  // Release the FIFO at once
    logic stop_now;   // Hold the FIFO regardless
  } drain_ctrl_t;

endpackage

//--- src/c2h_meta_gen.sv
/* DATA_WIDTH is a multiple of 64 and SEED is nonzero. The random source free-runs,
   so stub and inversion can change while a beat waits for the FIFO */
module c2h_meta_gen #(
  parameter int          DATA_WIDTH = 64,
  parameter logic [31:0] SEED       = 32'hb105f00d
) (
  input  logic                              user_clk,
  input  logic                              user_reset_n,
  input  c2h_gen_pkg::c2h_cmd_t             cur_cmd_i,
  input  logic [c2h_gen_pkg::LEN_WIDTH-1:0] byte_idx_i,
  output logic [DATA_WIDTH-1:0]             beat_data_o
);
  import c2h_gen_pkg::*;

  logic [31:0] rand_q;
  meta_ctrl_e  ctrl;
  meta_hdr_t   hdr;       // Before inversion
  meta_hdr_t   inv_mask;  // All ones except the control field
  meta_hdr_t   hdr_raw;   // As sent on the bus

  // 32-bit LFSR, taps 32 22 2 1
  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      rand_q <= SEED;
    end else begin
      rand_q <= {rand_q[30:0], rand_q[31] ^ rand_q[21] ^ rand_q[1] ^ rand_q[0]};
    end
  end

  assign ctrl = rand_q[8] ? META_PLAIN : META_INVERTED;  // Random inversion

  ////////////////////
  // Header fields
  always_comb begin
    hdr          = '0;
    hdr.stub     = rand_q[STUB_WIDTH-1:0];
    hdr.qid      = cur_cmd_i.qid;
    hdr.ctrl     = ctrl;
    hdr.byte_idx = byte_idx_i;
    hdr.len      = cur_cmd_i.len;
    for (int i = 0; i < CRC_WIDTH; i++) begin
      hdr.crc[i] = ^hdr[7*i +: 7];  // Bits 7i to 7i+6
    end
    inv_mask      = '1;
    inv_mask.ctrl = META_PLAIN;
    hdr_raw       = (ctrl == META_INVERTED) ? (hdr ^ inv_mask) : hdr;
  end

  assign beat_data_o = {(DATA_WIDTH / META_WIDTH){hdr_raw}};  // Same word in every lane

endmodule

//--- src/c2h_req_stage.sv
/* BYTE_CREDIT and MAX_CRDT are powers of two with BYTE_CREDIT below 64K.
   A zero credit count falls back to a single BYTE_CREDIT transfer */
module c2h_req_stage #(
  parameter int BYTE_CREDIT = 4096,
  parameter int MAX_CRDT    = 4
) (
  input  logic                              user_clk,
  input  logic                              user_reset_n,
  input  logic                              credit_vld_i,  // Credited queue offered
  input  logic [c2h_gen_pkg::QID_WIDTH-1:0] qid_i,
  input  logic [c2h_gen_pkg::LEN_WIDTH-1:0] credit_in_i,   // Descriptor credits
  input  logic [c2h_gen_pkg::LEN_WIDTH-1:0] req_len_i,     // Requested bytes
  input  logic                              take_i,        // Sequencer starts it
  output logic                              credit_rdy_o,
  output logic                              req_vld_o,
  output c2h_gen_pkg::c2h_cmd_t             req_cmd_o
);
  import c2h_gen_pkg::*;

  logic [LEN_WIDTH-1:0] eff_crdt;  // Credits capped at MAX_CRDT
  logic [LEN_WIDTH:0]   window;    // Bytes the capped credits cover
  logic [LEN_WIDTH:0]   rem;
  logic                 accept;
  c2h_cmd_t             new_cmd;

  assign credit_rdy_o = ~req_vld_o | take_i;  // Slot empty or emptying now
  assign accept       = credit_vld_i & credit_rdy_o;

  ////////////////////
  // Length rule
  always_comb begin
    eff_crdt    = (credit_in_i > MAX_CRDT) ? LEN_WIDTH'(MAX_CRDT) : credit_in_i;
    window      = (LEN_WIDTH+1)'(eff_crdt) * (LEN_WIDTH+1)'(BYTE_CREDIT);
    rem         = (window == '0) ? '0 : (req_len_i % window);
    new_cmd.qid = qid_i;
    new_cmd.len = (rem == '0) ? LEN_WIDTH'(BYTE_CREDIT) : rem[LEN_WIDTH-1:0];  // Never zero
  end

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      req_vld_o <= 1'b0;
    end else if (accept) begin
      req_vld_o <= 1'b1;   // A take in the same cycle is replaced
    end else if (take_i) begin
      req_vld_o <= 1'b0;
    end
  end

  always_ff @(posedge user_clk) begin
    if (accept) begin
      req_cmd_o <= new_cmd;
    end
  end

  // Sequencer may only start what this slot holds
  a_take_needs_slot: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    take_i |-> req_vld_o);

endmodule

//--- src/c2h_stream_gen.sv
/* DATA_WIDTH is 64, 128, 256 or 512 and BYTE_CREDIT covers at least one beat.
   Completion and requeue each buffer two finished packets */
module c2h_stream_gen #(
  parameter int          DATA_WIDTH  = 64,
  parameter int          BYTE_CREDIT = 4096,
  parameter int          MAX_CRDT    = 4,
  parameter int          FIFO_DEPTH  = 2048,
  parameter int          IDLE_LIMIT  = 4095,
  parameter logic [31:0] SEED        = 32'hb105f00d
) (
  input  logic                              user_clk,
  input  logic                              user_reset_n,
  input  c2h_gen_pkg::drain_ctrl_t          drain_ctrl_i,
  input  logic [c2h_gen_pkg::LEN_WIDTH-1:0] req_len_i,
  // Credit manager
  input  logic                              credit_vld_i,
  input  logic [c2h_gen_pkg::QID_WIDTH-1:0] qid_i,
  input  logic [c2h_gen_pkg::LEN_WIDTH-1:0] credit_in_i,
  output logic                              credit_rdy_o,
  output logic [c2h_gen_pkg::QID_WIDTH-1:0] dec_qid_o,
  output logic                              dec_credit_o,
  output logic [c2h_gen_pkg::QID_WIDTH-1:0] requeue_qid_o,
  output logic                              requeue_credit_o,
  input  logic                              requeue_rdy_i,
  // Completion
  output logic [c2h_gen_pkg::QID_WIDTH-1:0] qid_wb_o,
  output logic [c2h_gen_pkg::LEN_WIDTH-1:0] btt_wb_o,
  output logic                              c2h_formed_o,
  input  logic                              cmpt_sent_i,
  input  logic                              wb_is_full_i,
  output logic                              c2h_fifo_full_o,
  // C2H stream
  output logic [DATA_WIDTH-1:0]             c2h_tdata_o,
  output logic [c2h_gen_pkg::LEN_WIDTH-1:0] c2h_len_o,
  output logic [c2h_gen_pkg::QID_WIDTH-1:0] c2h_qid_o,
  output logic                              c2h_tlast_o,
  output logic                              c2h_tvalid_o,
  input  logic                              c2h_tready_i
);
  import c2h_gen_pkg::*;

  c2h_cmd_t              req_cmd, cur_cmd, cmpt_cmd, rq_cmd;
  logic                  req_vld, take, room, done;
  logic                  beat_vld, beat_last, beat_rdy;
  logic [LEN_WIDTH-1:0]  byte_idx;
  logic [DATA_WIDTH-1:0] beat_data;
  logic                  cmpt_full, rq_full, rq_vld, fifo_vld, gate, almost_empty;

  // Queues must still have room after a push landing this cycle
  assign room          = ~(cmpt_full | rq_full) & ~(done & (c2h_formed_o | rq_vld));
  assign dec_qid_o     = cur_cmd.qid;
  assign qid_wb_o      = cmpt_cmd.qid;
  assign btt_wb_o      = cmpt_cmd.len;
  assign requeue_qid_o = rq_cmd.qid;
  assign requeue_credit_o = rq_vld;
  assign c2h_tvalid_o  = fifo_vld & gate;

  c2h_req_stage #(.BYTE_CREDIT(BYTE_CREDIT), .MAX_CRDT(MAX_CRDT)) req_stage_i (
    .user_clk, .user_reset_n, .credit_vld_i, .qid_i, .credit_in_i, .req_len_i,
    .take_i(take), .credit_rdy_o, .req_vld_o(req_vld), .req_cmd_o(req_cmd));

  c2h_beat_sequencer #(.DATA_WIDTH(DATA_WIDTH), .BYTE_CREDIT(BYTE_CREDIT)) beat_seq_i (
    .user_clk, .user_reset_n, .req_vld_i(req_vld), .req_cmd_i(req_cmd), .room_i(room),
    .beat_rdy_i(beat_rdy), .take_o(take), .beat_vld_o(beat_vld), .beat_last_o(beat_last),
    .cur_cmd_o(cur_cmd), .byte_idx_o(byte_idx), .done_o(done), .dec_credit_o);

  c2h_meta_gen #(.DATA_WIDTH(DATA_WIDTH), .SEED(SEED)) meta_gen_i (
    .user_clk, .user_reset_n, .cur_cmd_i(cur_cmd), .byte_idx_i(byte_idx),
    .beat_data_o(beat_data));

  c2h_done_queue cmpt_queue_i (
    .user_clk, .user_reset_n, .push_i(done), .push_cmd_i(cur_cmd), .pop_i(cmpt_sent_i),
    .full_o(cmpt_full), .vld_o(c2h_formed_o), .cmd_o(cmpt_cmd));

  c2h_done_queue requeue_queue_i (
    .user_clk, .user_reset_n, .push_i(done), .push_cmd_i(cur_cmd), .pop_i(requeue_rdy_i),
    .full_o(rq_full), .vld_o(rq_vld), .cmd_o(rq_cmd));

  ////////////////////
  // Burst buffer and release
  c2h_burst_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH),
                   .BYTE_CREDIT(BYTE_CREDIT)) burst_fifo_i (
    .user_clk, .user_reset_n, .wr_vld_i(beat_vld), .wr_data_i(beat_data),
    .wr_last_i(beat_last), .wr_qid_i(cur_cmd.qid), .wr_len_i(cur_cmd.len),
    .wr_rdy_o(beat_rdy), .rd_vld_o(fifo_vld), .rd_data_o(c2h_tdata_o),
    .rd_last_o(c2h_tlast_o), .rd_qid_o(c2h_qid_o), .rd_len_o(c2h_len_o),
    .rd_en_i(gate & c2h_tready_i), .almost_empty_o(almost_empty),
    .nearly_full_o(c2h_fifo_full_o));

  c2h_drain_ctrl #(.IDLE_LIMIT(IDLE_LIMIT)) drain_i (
    .user_clk, .user_reset_n, .ctrl_i(drain_ctrl_i), .wb_is_full_i,
    .wr_fire_i(beat_vld & beat_rdy), .almost_empty_i(almost_empty),
    .nearly_full_i(c2h_fifo_full_o), .gate_o(gate));

endmodule

//--- tb/c2h_tb_tasks.svh
/* Test tasks for tb_c2h_stream_gen, included in the module body.
   Relies on the testbench signals, queues and counters declared before the include */
`ifndef C2H_TB_TASKS_SVH
`define C2H_TB_TASKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Length rule: capped credits, window modulo, zero falls back to one credit
function automatic logic [15:0] expected_len(input int credit, input int req_len);
  int eff;
  int window;
  int r;
  eff    = (credit > MAX_CRDT) ? MAX_CRDT : credit;
  window = eff * BYTE_CREDIT;
  r      = (window == 0) ? 0 : (req_len % window);
  return (r == 0) ? 16'(BYTE_CREDIT) : 16'(r);
endfunction

task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
  checks++;
  assert (got === exp) else begin
    $display("mismatch %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_true(input logic cond, input string msg);
  checks++;
  assert (cond) else begin
    $display("%s", msg);
    errors++;
  end
endtask

// Offer one credited queue and hold it until the DUT takes it
task automatic send_req(input logic [10:0] qid, input int credit, input int req_len);
  credit_vld_i = 1'b1;
  qid_i        = qid;
  credit_in_i  = 16'(credit);
  req_len_i    = 16'(req_len);
  @(posedge user_clk);
  while (!credit_rdy_o) @(posedge user_clk);
  #10;
  credit_vld_i = 1'b0;
  sent_q.push_back({qid, expected_len(credit, req_len)});
endtask

////////////////////
// Header model
task automatic check_header(input logic [63:0] data, input logic [15:0] idx,
                            input logic [15:0] len, input logic [10:0] qid);
  logic [63:0] w;
  logic [7:0]  crc;
  w = data;
  check_true(w[33:32] == 2'b00 || w[33:32] == 2'b11, "control field holds a reserved code");
  if (w[33:32] == 2'b11) w = w ^ ~(64'h3 << 32);  // Control bits stay as sent
  for (int i = 0; i < 8; i++) begin
    crc[i] = ^w[7*i +: 7];
  end
  check_eq("hdr.crc", w[63:56], crc);
  check_eq("hdr.qid", w[44:34], qid);
  check_eq("hdr.byte_idx", w[31:16], idx);
  check_eq("hdr.len", w[15:0], len);
endtask

// Pop one sent packet and compare beats, decrements, completion and requeue
task automatic check_packet();
  c2h_cmd_t exp;
  beat_t    b;
  dec_t     d;
  c2h_cmd_t r;
  int       nb;
  int       nd;
  exp = sent_q.pop_front();
  nb  = (exp.len + 7) / 8;
  nd  = (exp.len + BYTE_CREDIT - 1) / BYTE_CREDIT;
  while (beat_q.size() < nb || dec_q.size() < nd || cmpt_q.size() < 1 || rq_q.size() < 1)
    @(posedge user_clk);
  for (int i = 0; i < nb; i++) begin
    b = beat_q.pop_front();
    check_eq("c2h_tlast_o", b.last, (i == nb - 1));
    check_eq("c2h_len_o", b.len, exp.len);
    check_eq("c2h_qid_o", b.qid, exp.qid);
    check_header(b.data, 16'(i * 8), exp.len, exp.qid);
  end
  for (int i = 0; i < nd; i++) begin
    d = dec_q.pop_front();
    check_eq("dec_qid_o", d.qid, exp.qid);
  end
  check_eq("qid_wb_o/btt_wb_o", cmpt_q.pop_front(), exp);
  r = rq_q.pop_front();
  check_eq("requeue_qid_o", r.qid, exp.qid);
endtask

// Checks n packets, then lines up with the stimulus phase again
task automatic check_sent(input int n);
  repeat (n) check_packet();
  @(posedge user_clk);
  #10;
  check_eq("dec_credit_o extra pulses", dec_q.size(), 0);
  check_eq("c2h_tvalid_o extra beats", beat_q.size(), 0);
endtask

task automatic report(input string name, input int err_before);
  tests_run++;
  if (errors == err_before) $display("test %s: ok", name);
  else $display("test %s: FAIL with %0d errors", name, errors - err_before);
endtask

`endif

//--- tb/tb_c2h_stream_gen.sv
/* Directed testbench for the C2H stream generator, 64-bit bus, 64-byte credits.
   Stimulus changes 10 ns after the rising edge, monitors sample on the edge */
module tb_c2h_stream_gen;
  timeunit 1ns;
  timeprecision 1ps;
  import c2h_gen_pkg::*;

  localparam int DATA_WIDTH  = 64;
  localparam int BYTE_CREDIT = 64;
  localparam int MAX_CRDT    = 4;
  localparam int FIFO_DEPTH  = 32;
  localparam int IDLE_LIMIT  = 63;
  // Worst beats per test, back-pressure run counted twice
  localparam int TEST_BEATS  = 1 + 8*32 + 6*32 + 3*32 + (5 + 2 + 32) + 16*32*2;
  localparam int TIMEOUT     = 2 * (TEST_BEATS + 6*IDLE_LIMIT + 60);

  typedef struct packed {
    logic [63:0] data;
    logic [15:0] len;
    logic [10:0] qid;
    logic        last;
    logic [31:0] cyc;   // Cycle of acceptance
  } beat_t;

  typedef struct packed {
    logic [10:0] qid;
    logic [31:0] cyc;
  } dec_t;

  logic                  user_clk;
  logic                  user_reset_n;
  drain_ctrl_t           drain_ctrl_i;
  logic [15:0]           req_len_i;
  logic                  credit_vld_i;
  logic [10:0]           qid_i;
  logic [15:0]           credit_in_i;
  logic                  credit_rdy_o;
  logic [10:0]           dec_qid_o;
  logic                  dec_credit_o;
  logic [10:0]           requeue_qid_o;
  logic                  requeue_credit_o;
  logic                  requeue_rdy_i;
  logic [10:0]           qid_wb_o;
  logic [15:0]           btt_wb_o;
  logic                  c2h_formed_o;
  logic                  cmpt_sent_i;
  logic                  wb_is_full_i;
  logic                  c2h_fifo_full_o;
  logic [DATA_WIDTH-1:0] c2h_tdata_o;
  logic [15:0]           c2h_len_o;
  logic [10:0]           c2h_qid_o;
  logic                  c2h_tlast_o;
  logic                  c2h_tvalid_o;
  logic                  c2h_tready_i;

  beat_t       beat_q[$];   // Accepted output beats
  dec_t        dec_q[$];
  c2h_cmd_t    cmpt_q[$];   // Popped completions
  c2h_cmd_t    rq_q[$];     // Popped requeues
  c2h_cmd_t    sent_q[$];   // Expected packets in request order
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  logic        bp_en = 1'b0;
  logic [31:0] rng = 32'd14;
  logic [31:0] bp_rng = 32'd14;

  `include "c2h_tb_tasks.svh"

  c2h_stream_gen #(
    .DATA_WIDTH(DATA_WIDTH), .BYTE_CREDIT(BYTE_CREDIT), .MAX_CRDT(MAX_CRDT),
    .FIFO_DEPTH(FIFO_DEPTH), .IDLE_LIMIT(IDLE_LIMIT)
  ) c2h_stream_gen_i (.*);

  initial user_clk = 1'b0;
  always #50 user_clk = ~user_clk;  // 100 ns period

  ////////////////////
  // Monitors
  always @(posedge user_clk) begin
    cycle <= cycle + 1;
    if (user_reset_n) begin
      if (c2h_tvalid_o && c2h_tready_i)
        beat_q.push_back({c2h_tdata_o, c2h_len_o, c2h_qid_o, c2h_tlast_o, 32'(cycle)});
      if (dec_credit_o) dec_q.push_back({dec_qid_o, 32'(cycle)});
      if (c2h_formed_o && cmpt_sent_i) cmpt_q.push_back({qid_wb_o, btt_wb_o});
      if (requeue_credit_o && requeue_rdy_i) rq_q.push_back({requeue_qid_o, 16'h0});
    end
  end

  always @(posedge user_clk) begin
    if (cycle >= TIMEOUT) begin
      $display("run stopped at the cycle limit of %0d", TIMEOUT);
      $display("tests failed");
      $finish;
    end
  end

  // Pseudo-random output back-pressure
  always @(posedge user_clk) begin
    #10;
    if (bp_en) begin
      bp_rng       = xorshift(bp_rng);
      c2h_tready_i = bp_rng[4];
    end
  end

  initial begin
    int e;
    int first;
    int n;
    user_reset_n  = 1'b0;
    drain_ctrl_i  = '{start_now: 1'b1, stop_now: 1'b0};
    req_len_i     = '0;
    credit_vld_i  = 1'b0;
    qid_i         = '0;
    credit_in_i   = '0;
    requeue_rdy_i = 1'b1;
    cmpt_sent_i   = 1'b1;
    wb_is_full_i  = 1'b0;
    c2h_tready_i  = 1'b1;
    repeat (3) @(posedge user_clk);
    #10;
    user_reset_n = 1'b1;

    e = errors;  // Single beat
    rng = xorshift(rng);
    send_req(rng[10:0], 1, 8);
    check_sent(1);
    report("single_beat", e);

    e = errors;  // Multi beat, random lengths
    repeat (8) begin
      rng = xorshift(rng);
      send_req(rng[26:16], 4, 1 + rng[15:0] % 300);
    end
    check_sent(8);
    report("multi_beat", e);

    e = errors;  // Length rule, credit 7 is capped
    send_req(11'd1, 1, 64);
    send_req(11'd2, 1, 100);
    send_req(11'd3, 3, 384);
    send_req(11'd4, 3, 200);
    send_req(11'd5, 7, 512);
    send_req(11'd6, 7, 300);
    check_sent(6);
    report("length_rule", e);

    e = errors;  // Queues fill, third request stays pending
    cmpt_sent_i   = 1'b0;
    requeue_rdy_i = 1'b0;
    send_req(11'h10, 1, 16);
    send_req(11'h11, 1, 16);
    send_req(11'h12, 1, 16);
    repeat (30) @(posedge user_clk);
    check_eq("credit_rdy_o", credit_rdy_o, 1'b0);
    check_eq("beats before acknowledge", beat_q.size(), 4);
    #10;
    cmpt_sent_i   = 1'b1;
    requeue_rdy_i = 1'b1;
    check_sent(3);
    report("queue_order", e);

    e = errors;  // Idle timeout release
    drain_ctrl_i.start_now = 1'b0;
    repeat (5) @(posedge user_clk);
    #10;
    send_req(11'h20, 1, 40);
    while (beat_q.size() < 1 || dec_q.size() < 1) @(posedge user_clk);
    first = beat_q[0].cyc;
    check_true(first - int'(dec_q[dec_q.size()-1].cyc) > IDLE_LIMIT,
               "output released before the idle limit");
    check_sent(1);
    @(posedge user_clk);
    #10;
    drain_ctrl_i = '{start_now: 1'b1, stop_now: 1'b1};
    send_req(11'h21, 1, 16);
    repeat (20) @(posedge user_clk);
    check_true(beat_q.size() == 0 && !c2h_tvalid_o, "output valid while stop_now held");
    #10;
    drain_ctrl_i.stop_now = 1'b0;
    check_sent(1);
    @(posedge user_clk);
    #10;
    drain_ctrl_i = '{start_now: 1'b0, stop_now: 1'b1};
    send_req(11'h22, 4, 255);
    n = 0;
    while (n < 3) begin  // Third credit boundary is the 24th write
      @(posedge user_clk);
      if (dec_credit_o) n++;
    end
    @(posedge user_clk);
    check_eq("c2h_fifo_full_o", c2h_fifo_full_o, 1'b0);  // 8 entries free
    @(posedge user_clk);
    check_eq("c2h_fifo_full_o", c2h_fifo_full_o, 1'b1);  // 7 entries free
    #10;
    drain_ctrl_i = '{start_now: 1'b1, stop_now: 1'b0};
    check_sent(1);
    report("drain_control", e);

    e = errors;  // Output back-pressure
    bp_en = 1'b1;
    repeat (16) begin
      rng = xorshift(rng);
      send_req(rng[26:16], 1 + rng[2:0], 1 + rng[15:0] % 1024);
    end
    check_sent(16);
    bp_en = 1'b0;
    #20;
    c2h_tready_i = 1'b1;
    report("back_pressure", e);

    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
